// ==== src.f ====
gps_pkg.sv
ca_code_gen.sv
carrier_nco.sv
carrier_wipe.sv
code_accumulator.sv
subchannel_ctrl.sv
subchannel.sv
tb_subchannel.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_subchannel \
   && ./obj_dir/Vtb_subchannel > sim.log 2>&1 \
   || echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -q "TESTBENCH PASSED" sim.log \
   && echo "run_sim: PASS" \
   || { echo "run_sim: FAIL"; exit 1; }

// ==== tb_subchannel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_subchannel
   import gps_pkg::*;
();

   localparam int  CLK_PERIOD        = 20;
   localparam int  SAMPLES_PER_EPOCH = CHIPS_PER_EPOCH * SAMPLES_PER_CHIP;
   localparam int  TESTED_EPOCHS     = 7;
   localparam time DUMP_LATENCY      = 2 * CLK_PERIOD + CLK_PERIOD / 2;
   // First ten chips of PRN 1, first chip in the MSB.
   localparam logic [9:0] PRN1_HEAD  = 10'b1100100000;

   logic                       clk;
   logic                       rst_n_i;
   logic                       data_valid_i;
   logic signed [SAMPLE_W-1:0] data_i;
   logic [DOPPLER_W-1:0]       doppler_i;
   logic [4:0]                 prn_i;
   logic                       seek_en_i;
   logic [CS_W-1:0]            seek_target_i;
   logic [CS_W-1:0]            code_shift_o;
   logic                       seeking_o;
   logic                       dump_valid_o;
   corr_t                      dump_o;
   logic                       ca_chip_o;

   // Software model of code, carrier and sums.
   logic [LFSR_W-1:0]           m_g1;
   logic [LFSR_W-1:0]           m_g2;
   int                          m_sub;
   int                          m_chip;
   logic [PHASE_W-1:0]          m_phase;
   logic signed [DOPPLER_W-1:0] m_doppler;
   logic [4:0]                  m_prn;
   corr_t                       m_acc;
   int                          m_epochs;
   corr_t                       exp_q[$];
   time                         exp_t_q[$];

   integer seed;
   int     chk_errors = 0;
   int     cmp_errors = 0;
   int     dumps_seen = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     test_err_base = 0;
   int     strobes_sent = 0;
   int     dump_strobes = 0;

   subchannel subchannel_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic void model_reset();
      m_g1   = '1;
      m_g2   = '1;
      m_sub  = 0;
      m_chip = 0;
      m_acc  = '0;
   endfunction

   function automatic logic model_chip();
      return m_g1[LFSR_W-1] ^ (^(m_g2 & g2_taps(m_prn)));
   endfunction

   // G1 taps 3 and 10, G2 taps 2, 3, 6, 8, 9 and 10.
   function automatic void model_step_chip();
      m_g1   = {m_g1[LFSR_W-2:0], m_g1[2] ^ m_g1[9]};
      m_g2   = {m_g2[LFSR_W-2:0], m_g2[1] ^ m_g2[2] ^ m_g2[5] ^ m_g2[7] ^ m_g2[8] ^ m_g2[9]};
      m_chip = (m_chip + 1) % CHIPS_PER_EPOCH;
      m_sub  = 0;
   endfunction

   function automatic void model_seek(input int target);
      model_reset();
      for (int k = 0; k < target; k++) begin
         model_step_chip();
      end
   endfunction

   // One sample through carrier wipe, code wipe and the sums.
   function automatic void model_sample(input logic signed [SAMPLE_W-1:0] s);
      logic [LUT_IDX_W-1:0]     idx;
      logic signed [PROD_W-1:0] pi;
      logic signed [PROD_W-1:0] pq;
      logic signed [ACC_W-1:0]  ti;
      logic signed [ACC_W-1:0]  tq;
      idx = m_phase[PHASE_W-1 -: LUT_IDX_W];
      pi  = s * cos_lut(idx);
      pq  = s * sin_lut(idx);
      ti  = {{(ACC_W - PROD_W){pi[PROD_W-1]}}, pi};
      tq  = {{(ACC_W - PROD_W){pq[PROD_W-1]}}, pq};
      if (model_chip()) begin
         ti = -ti;
         tq = -tq;
      end
      m_acc.i = m_acc.i + ti;
      m_acc.q = m_acc.q + tq;
      if (m_chip == CHIPS_PER_EPOCH - 1 && m_sub == SAMPLES_PER_CHIP - 1) begin
         exp_q.push_back(m_acc);
         exp_t_q.push_back($time);
         m_acc = '0;
         m_epochs++;
      end
      if (m_sub == SAMPLES_PER_CHIP - 1) begin
         model_step_chip();
      end else begin
         m_sub++;
      end
      m_phase = m_phase + F_IF_INC +
                {{(PHASE_W - DOPPLER_W){m_doppler[DOPPLER_W-1]}}, m_doppler};
   endfunction

   task automatic send_sample();
      logic [31:0] rnd;
      rnd = $random(seed);
      @(posedge clk);
      data_valid_i <= 1'b1;
      data_i       <= rnd[SAMPLE_W-1:0];
      strobes_sent++;
      model_sample(rnd[SAMPLE_W-1:0]);
      @(posedge clk);
      data_valid_i <= 1'b0;
   endtask

   // Runs until the model closes n more epochs and all dumps are in.
   task automatic run_epochs(input int n);
      int target;
      target = m_epochs + n;
      while (m_epochs < target) begin
         send_sample();
      end
      wait (dumps_seen == m_epochs);
      repeat (4) @(posedge clk);
   endtask

   task automatic set_doppler(input logic signed [DOPPLER_W-1:0] d);
      @(posedge clk);
      doppler_i <= d;
      m_doppler  = d;
   endtask

   // Returns the number of cycles that seeking_o stayed high.
   task automatic seek_to(input int target, output int cycles);
      @(posedge clk);
      seek_en_i     <= 1'b1;
      seek_target_i <= CS_W'(target);
      @(posedge clk);
      seek_en_i <= 1'b0;
      cycles = 0;
      @(negedge clk);
      while (seeking_o) begin
         cycles++;
         @(negedge clk);
      end
   endtask

   task automatic check_seek(input int target, input int cycles);
      if (cycles != target + 1) begin
         $display("MISMATCH at %0t: seek to %0d held seeking_o %0d cycles, expected %0d",
                  $time, target, cycles, target + 1);
         chk_errors++;
      end
      if (int'(code_shift_o) != target) begin
         $display("MISMATCH at %0t: code_shift_o is %0d after seek, expected %0d",
                  $time, code_shift_o, target);
         chk_errors++;
      end
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = chk_errors + cmp_errors - test_err_base;
      tests_run++;
      if (errs == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
      end
      test_err_base = chk_errors + cmp_errors;
   endtask

   // Dumps are sampled mid-cycle, away from the clock edge.
   always @(negedge clk) begin
      if (rst_n_i && dump_valid_o) begin
         dump_strobes = strobes_sent;
         if (dumps_seen >= exp_q.size()) begin
            $display("ERROR at %0t: dump_valid_o pulsed when no epoch had ended", $time);
            cmp_errors++;
         end else begin
            if (dump_o.i !== exp_q[dumps_seen].i || dump_o.q !== exp_q[dumps_seen].q) begin
               $display("MISMATCH at %0t: dump %0d got I=%0d Q=%0d, expected I=%0d Q=%0d",
                        $time, dumps_seen, dump_o.i, dump_o.q,
                        exp_q[dumps_seen].i, exp_q[dumps_seen].q);
               cmp_errors++;
            end
            if ($time - exp_t_q[dumps_seen] != DUMP_LATENCY) begin
               $display("MISMATCH at %0t: dump %0d came %0d ns after its last strobe",
                        $time, dumps_seen, $time - exp_t_q[dumps_seen]);
               cmp_errors++;
            end
         end
         dumps_seen++;
      end
   end

   initial begin
      #(TESTED_EPOCHS * SAMPLES_PER_EPOCH * 2 * CLK_PERIOD + 50_000);
      $display("ERROR: watchdog expired before all tests finished");
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      int cycles;
      int seek_base;
      seed          = 32'h2502_3e65;
      rst_n_i       = 1'b0;
      data_valid_i  = 1'b0;
      data_i        = '0;
      doppler_i     = '0;
      prn_i         = 5'd1;
      seek_en_i     = 1'b0;
      seek_target_i = '0;
      m_prn         = 5'd1;
      m_doppler     = '0;
      m_phase       = '0;
      m_epochs      = 0;
      model_reset();
      repeat (10) @(posedge clk);
      rst_n_i <= 1'b1;
      @(negedge clk);

      if (seeking_o !== 1'b0 || dump_valid_o !== 1'b0 || code_shift_o !== '0 ||
          dump_o !== '0) begin
         $display("MISMATCH at %0t: outputs are not idle after reset", $time);
         chk_errors++;
      end
      for (int k = 0; k < 10; k++) begin
         @(negedge clk);
         if (ca_chip_o !== PRN1_HEAD[9-k] || ca_chip_o !== model_chip()) begin
            $display("MISMATCH at %0t: PRN 1 chip %0d got %b, expected %b",
                     $time, k, ca_chip_o, PRN1_HEAD[9-k]);
            chk_errors++;
         end
         repeat (SAMPLES_PER_CHIP) send_sample();
      end
      end_test("reset state and PRN 1 code head");

      run_epochs(2);
      end_test("zero Doppler epoch dumps");

      set_doppler(16'sh0B50);
      run_epochs(1);
      set_doppler(-16'sd9000);
      run_epochs(1);
      end_test("positive and negative Doppler");

      // Seek in the middle of an epoch, so the partial sums must clear.
      repeat (100) send_sample();
      repeat (4) @(posedge clk);
      seek_to(700, cycles);
      check_seek(700, cycles);
      model_seek(700);
      seek_base = strobes_sent;
      run_epochs(1);
      if (dump_strobes - seek_base != (CHIPS_PER_EPOCH - 700) * SAMPLES_PER_CHIP) begin
         $display("MISMATCH at %0t: first dump after seek came after %0d samples",
                  $time, dump_strobes - seek_base);
         chk_errors++;
      end
      end_test("seek to code shift 700");

      @(posedge clk);
      prn_i <= 5'd17;
      m_prn  = 5'd17;
      seek_to(0, cycles);
      check_seek(0, cycles);
      model_seek(0);
      run_epochs(2);
      end_test("PRN 17 after reseek");

      $display("%0d tests run, %0d failed, %0d dumps checked, %0d errors",
               tests_run, tests_failed, dumps_seen, chk_errors + cmp_errors);
      if (tests_failed == 0 && chk_errors + cmp_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== subchannel.sv ====
`timescale 1ns/1ps
`default_nettype none

module subchannel
   import gps_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       data_valid_i,
   input  logic signed [SAMPLE_W-1:0] data_i,
   input  logic [DOPPLER_W-1:0]       doppler_i,
   input  logic [4:0]                 prn_i,
   input  logic                       seek_en_i,
   input  logic [CS_W-1:0]            seek_target_i,
   output logic [CS_W-1:0]            code_shift_o,
   output logic                       seeking_o,
   output logic                       dump_valid_o,
   output corr_t                      dump_o,
   output logic                       ca_chip_o
);

   logic     sample_adv;
   logic     seek_step;
   logic     code_load;
   logic     acc_clear;
   logic     acc_dump;
   logic     epoch;
   carrier_t carrier;
   wiped_t   wiped;

   subchannel_ctrl ctrl_i (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .data_valid_i  (data_valid_i),
      .seek_en_i     (seek_en_i),
      .seek_target_i (seek_target_i),
      .code_shift_i  (code_shift_o),
      .epoch_i       (epoch),
      .sample_adv_o  (sample_adv),
      .seek_step_o   (seek_step),
      .code_load_o   (code_load),
      .acc_clear_o   (acc_clear),
      .dump_o        (acc_dump),
      .seeking_o     (seeking_o)
   );

   ca_code_gen code_gen_i (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .prn_i        (prn_i),
      .sample_adv_i (sample_adv),
      .seek_step_i  (seek_step),
      .load_i       (code_load),
      .chip_o       (ca_chip_o),
      .code_shift_o (code_shift_o),
      .epoch_o      (epoch)
   );

   // Carrier holds its phase through a seek.
   carrier_nco nco_i (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .adv_i     (sample_adv),
      .doppler_i (doppler_i),
      .carrier_o (carrier)
   );

   carrier_wipe wipe_i (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .valid_i    (sample_adv),
      .data_i     (data_i),
      .carrier_i  (carrier),
      .code_bit_i (ca_chip_o),
      .wiped_o    (wiped)
   );

   // Prompt correlator only.
   code_accumulator acc_i (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .wiped_i      (wiped),
      .dump_i       (acc_dump),
      .clear_i      (acc_clear),
      .dump_valid_o (dump_valid_o),
      .result_o     (dump_o)
   );

endmodule

`default_nettype wire

// ==== subchannel_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module subchannel_ctrl
   import gps_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n_i,
   input  logic            data_valid_i,
   input  logic            seek_en_i,
   input  logic [CS_W-1:0] seek_target_i,
   input  logic [CS_W-1:0] code_shift_i,
   input  logic            epoch_i,
   output logic            sample_adv_o,
   output logic            seek_step_o,
   output logic            code_load_o,
   output logic            acc_clear_o,
   output logic            dump_o,
   output logic            seeking_o
);

   chan_state_e     state_q;
   chan_state_e     state_nxt;
   logic [CS_W-1:0] target_q;
   logic            epoch_q;

   // CH_IDLE is the single load cycle that opens every seek.
   always_comb begin
      state_nxt = state_q;
      case (state_q)
         CH_IDLE: begin
            if (target_q == '0) begin
               state_nxt = CH_TRACK;
            end else begin
               state_nxt = CH_SEEK;
            end
         end
         CH_SEEK: begin
            // The step in this cycle lands on the target.
            if (code_shift_i + CS_W'(1) == target_q) begin
               state_nxt = CH_TRACK;
            end
         end
         default: state_nxt = CH_TRACK;
      endcase
      if (seek_en_i) begin
         state_nxt = CH_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state_q <= CH_TRACK;
         epoch_q <= 1'b0;
      end else begin
         state_q <= state_nxt;
         epoch_q <= epoch_i;
      end
   end

   always_ff @(posedge clk) begin
      if (seek_en_i) begin
         target_q <= seek_target_i;
      end
   end

   // Samples that arrive while seeking are dropped.
   assign sample_adv_o = data_valid_i && (state_q == CH_TRACK);
   assign code_load_o  = (state_q == CH_IDLE);
   assign acc_clear_o  = (state_q == CH_IDLE);
   assign seek_step_o  = (state_q == CH_SEEK);
   assign seeking_o    = (state_q != CH_TRACK);

   // One cycle late, to line up with the registered product.
   assign dump_o = epoch_q;

   a_strobe_spacing: assert property (@(posedge clk) disable iff (!rst_n_i)
      data_valid_i |=> !data_valid_i);

   // A step never starts from the target, so a seek cannot overshoot.
   a_no_step_past_target: assert property (@(posedge clk) disable iff (!rst_n_i)
      seek_step_o |-> (code_shift_i != target_q));

endmodule

`default_nettype wire

// ==== code_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module code_accumulator
   import gps_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n_i,
   input  wiped_t wiped_i,
   input  logic   dump_i,
   input  logic   clear_i,
   output logic   dump_valid_o,
   output corr_t  result_o
);

   corr_t sum_q;
   corr_t term;
   corr_t total;

   // Code wipe-off. A code bit of 1 flips the sign of the product.
   function automatic logic signed [ACC_W-1:0] wipe_term(
      input logic signed [PROD_W-1:0] prod,
      input logic                     code_bit
   );
      logic signed [ACC_W-1:0] ext;
      ext = {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
      return code_bit ? -ext : ext;
   endfunction

   assign term.i = wipe_term(wiped_i.i, wiped_i.code_bit);
   assign term.q = wipe_term(wiped_i.q, wiped_i.code_bit);

   assign total.i = sum_q.i + term.i;
   assign total.q = sum_q.q + term.q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         sum_q        <= '0;
         result_o     <= '0;
         dump_valid_o <= 1'b0;
      end else begin
         dump_valid_o <= 1'b0;
         if (wiped_i.valid && dump_i) begin
            // Final product of the epoch goes straight into the result.
            result_o     <= total;
            dump_valid_o <= 1'b1;
            sum_q        <= '0;
         end else if (clear_i) begin
            sum_q <= '0;
         end else if (wiped_i.valid) begin
            sum_q <= total;
         end
      end
   end

endmodule

`default_nettype wire

// ==== carrier_wipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module carrier_wipe
   import gps_pkg::*;
(
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       valid_i,
   input  logic signed [SAMPLE_W-1:0] data_i,
   input  carrier_t                   carrier_i,
   input  logic                       code_bit_i,
   output wiped_t                     wiped_o
);

   logic signed [PROD_W-1:0] prod_i;
   logic signed [PROD_W-1:0] prod_q;
   logic                     valid_q;
   logic                     code_bit_q;
   logic signed [PROD_W-1:0] i_q;
   logic signed [PROD_W-1:0] q_q;

   // Both operands signed, so the product comes out signed at PROD_W.
   assign prod_i = data_i * carrier_i.cos;
   assign prod_q = data_i * carrier_i.sin;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_i) begin
         code_bit_q <= code_bit_i;
         i_q        <= prod_i;
         q_q        <= prod_q;
      end
   end

   assign wiped_o = '{valid: valid_q, code_bit: code_bit_q, i: i_q, q: q_q};

endmodule

`default_nettype wire

// ==== carrier_nco.sv ====
`timescale 1ns/1ps
`default_nettype none

module carrier_nco
   import gps_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 adv_i,
   input  logic [DOPPLER_W-1:0] doppler_i,
   output carrier_t             carrier_o
);

   logic [PHASE_W-1:0]   phase_q;
   logic [PHASE_W-1:0]   phase_inc;
   logic [LUT_IDX_W-1:0] lut_idx;

   // Doppler is two's complement, so sign-extend before the add.
   assign phase_inc = F_IF_INC +
                      {{(PHASE_W - DOPPLER_W){doppler_i[DOPPLER_W-1]}}, doppler_i};

   // Wraps modulo 2^PHASE_W.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         phase_q <= '0;
      end else if (adv_i) begin
         phase_q <= phase_q + phase_inc;
      end
   end

   // The sample in flight sees the phase before this cycle's update.
   assign lut_idx = phase_q[PHASE_W-1 -: LUT_IDX_W];

   assign carrier_o = '{cos: cos_lut(lut_idx), sin: sin_lut(lut_idx)};

endmodule

`default_nettype wire

// ==== ca_code_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ca_code_gen
   import gps_pkg::*;
(
   input  logic            clk,
   input  logic            rst_n_i,
   input  logic [4:0]      prn_i,
   input  logic            sample_adv_i,
   input  logic            seek_step_i,
   input  logic            load_i,
   output logic            chip_o,
   output logic [CS_W-1:0] code_shift_o,
   output logic            epoch_o
);

   localparam logic [CS_W-1:0]  LAST_CHIP = CS_W'(CHIPS_PER_EPOCH - 1);
   localparam logic [SUB_W-1:0] LAST_SUB  = SUB_W'(SAMPLES_PER_CHIP - 1);

   // Bit 0 is stage 1, bit 9 is stage 10.
   logic [LFSR_W-1:0] g1_q;
   logic [LFSR_W-1:0] g2_q;
   logic [LFSR_W-1:0] g1_shift;
   logic [LFSR_W-1:0] g2_shift;
   logic [SUB_W-1:0]  sub_q;
   logic [CS_W-1:0]   chip_q;
   logic [CS_W-1:0]   chip_inc;

   // G1 = 1 + x^3 + x^10, G2 = 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10.
   assign g1_shift = {g1_q[LFSR_W-2:0], g1_q[2] ^ g1_q[9]};
   assign g2_shift = {g2_q[LFSR_W-2:0],
                      g2_q[1] ^ g2_q[2] ^ g2_q[5] ^ g2_q[7] ^ g2_q[8] ^ g2_q[9]};

   assign chip_inc = (chip_q == LAST_CHIP) ? '0 : chip_q + CS_W'(1);

   always_ff @(posedge clk) begin
      if (!rst_n_i || load_i) begin
         g1_q   <= '1;
         g2_q   <= '1;
         sub_q  <= '0;
         chip_q <= '0;
      end else if (seek_step_i) begin
         // A whole chip per cycle. The sub-chip phase restarts.
         g1_q   <= g1_shift;
         g2_q   <= g2_shift;
         sub_q  <= '0;
         chip_q <= chip_inc;
      end else if (sample_adv_i) begin
         if (sub_q == LAST_SUB) begin
            g1_q   <= g1_shift;
            g2_q   <= g2_shift;
            sub_q  <= '0;
            chip_q <= chip_inc;
         end else begin
            sub_q <= sub_q + SUB_W'(1);
         end
      end
   end

   assign chip_o       = g1_q[LFSR_W-1] ^ (^(g2_q & g2_taps(prn_i)));
   assign code_shift_o = chip_q;

   // Last sample of chip 1022 closes the epoch.
   assign epoch_o = sample_adv_i && !seek_step_i && !load_i &&
                    (chip_q == LAST_CHIP) && (sub_q == LAST_SUB);

   a_shift_range: assert property (@(posedge clk) disable iff (!rst_n_i)
      code_shift_o < CS_W'(CHIPS_PER_EPOCH));

endmodule

`default_nettype wire

// ==== gps_pkg.sv ====
`default_nettype none

package gps_pkg;

   // Datapath widths.
   localparam int SAMPLE_W  = 3;
   localparam int CARRIER_W = 3;
   localparam int PROD_W    = 6;
   localparam int ACC_W     = 20;

   // Carrier NCO.
   localparam int PHASE_W   = 24;
   localparam int DOPPLER_W = 16;
   localparam int LUT_IDX_W = 3;
   localparam logic [PHASE_W-1:0] F_IF_INC = 24'h47_AE14;

   // C/A code.
   localparam int CHIPS_PER_EPOCH  = 1023;
   localparam int SAMPLES_PER_CHIP = 4;
   localparam int CS_W             = 10;
   localparam int SUB_W            = $clog2(SAMPLES_PER_CHIP);
   localparam int LFSR_W           = 10;

   typedef enum logic [1:0] {
      CH_IDLE,
      CH_SEEK,
      CH_TRACK
   } chan_state_e;

   typedef struct packed {
      logic signed [CARRIER_W-1:0] cos;
      logic signed [CARRIER_W-1:0] sin;
   } carrier_t;

   typedef struct packed {
      logic                     valid;
      logic                     code_bit;
      logic signed [PROD_W-1:0] i;
      logic signed [PROD_W-1:0] q;
   } wiped_t;

   typedef struct packed {
      logic signed [ACC_W-1:0] i;
      logic signed [ACC_W-1:0] q;
   } corr_t;

   // Eight-point cosine, amplitudes 1 and 2.
   function automatic logic signed [CARRIER_W-1:0] cos_lut(input logic [LUT_IDX_W-1:0] idx);
      case (idx)
         3'd0: return CARRIER_W'(2);
         3'd1: return CARRIER_W'(1);
         3'd2: return CARRIER_W'(-1);
         3'd3: return CARRIER_W'(-2);
         3'd4: return CARRIER_W'(-2);
         3'd5: return CARRIER_W'(-1);
         3'd6: return CARRIER_W'(1);
         default: return CARRIER_W'(2);
      endcase
   endfunction

   function automatic logic signed [CARRIER_W-1:0] sin_lut(input logic [LUT_IDX_W-1:0] idx);
      case (idx)
         3'd0: return CARRIER_W'(1);
         3'd1: return CARRIER_W'(2);
         3'd2: return CARRIER_W'(2);
         3'd3: return CARRIER_W'(1);
         3'd4: return CARRIER_W'(-1);
         3'd5: return CARRIER_W'(-2);
         3'd6: return CARRIER_W'(-2);
         default: return CARRIER_W'(-1);
      endcase
   endfunction

   // G2 phase select. Each hex digit of pos is a 1-based stage number,
   // the result has one bit set per selected stage.
   function automatic logic [LFSR_W-1:0] g2_taps(input logic [4:0] prn);
      logic [7:0] pos;
      case (prn)
         5'd1:  pos = 8'h26;
         5'd2:  pos = 8'h37;
         5'd3:  pos = 8'h48;
         5'd4:  pos = 8'h59;
         5'd5:  pos = 8'h19;
         5'd6:  pos = 8'h2A;
         5'd7:  pos = 8'h18;
         5'd8:  pos = 8'h29;
         5'd9:  pos = 8'h3A;
         5'd10: pos = 8'h23;
         5'd11: pos = 8'h34;
         5'd12: pos = 8'h56;
         5'd13: pos = 8'h67;
         5'd14: pos = 8'h78;
         5'd15: pos = 8'h89;
         5'd16: pos = 8'h9A;
         5'd17: pos = 8'h14;
         5'd18: pos = 8'h25;
         5'd19: pos = 8'h36;
         5'd20: pos = 8'h47;
         5'd21: pos = 8'h58;
         5'd22: pos = 8'h69;
         5'd23: pos = 8'h13;
         5'd24: pos = 8'h46;
         5'd25: pos = 8'h57;
         5'd26: pos = 8'h68;
         5'd27: pos = 8'h79;
         5'd28: pos = 8'h8A;
         5'd29: pos = 8'h16;
         5'd30: pos = 8'h27;
         5'd31: pos = 8'h38;
         default: pos = 8'h49;  // Value 0 encodes PRN 32.
      endcase
      return (LFSR_W'(1) << (pos[7:4] - 4'd1)) | (LFSR_W'(1) << (pos[3:0] - 4'd1));
   endfunction

endpackage

`default_nettype wire
